//--- build.f
+incdir+include
rtl/memBusPkg.sv
rtl/bankPkg.sv
rtl/spramBank.sv
rtl/spramArray.sv
rtl/reqMerge.sv
rtl/readSteer.sv
rtl/forthMemTop.sv
dv/forthMem_chk.sv
dv/forthMemTb.sv

//--- run.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
# The exit status is that of the simulation, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f build.f \
    --top-module forthMemTb \
    --Mdir obj_dir \
    -o forthMemSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/forthMemSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- dv/forthMemTb.sv
// Testbench for the stack processor memory subsystem.
// Applies a table of word and byte port requests and checks every read
// against a byte-wide reference model of the 128 KiB RAM.

`timescale 1ns/1ps
`default_nettype none

`include "spram_settings.svh"

module forthMemTb;

    localparam logic PortWord       = 1'b0;
    localparam logic PortByte       = 1'b1;
    localparam int   ResetTimeout   = 64;    // cycles
    localparam int   WatchdogCycles = 2000;

    // word addresses, bit 14 picks the bank pair
    localparam logic [`SPRAM_WORD_AW-1:0] AddrLo0 = 15'h0010;
    localparam logic [`SPRAM_WORD_AW-1:0] AddrHi0 = 15'h4010;  // same bank address, other pair
    localparam logic [`SPRAM_WORD_AW-1:0] AddrLo1 = 15'h0123;
    localparam logic [`SPRAM_WORD_AW-1:0] AddrHi1 = 15'h7ffe;

    // one table entry
    typedef struct packed {
        logic                      port;
        logic                      we;
        logic [3:0]                mask;  // word port only
        logic [`SPRAM_BYTE_AW-1:0] addr;  // word address sits in the low bits for the word port
        logic [31:0]               data;
    } stepT;

    logic               clk;
    logic               arstN;
    logic               debugSel;
    memBusPkg::wordReqT wordReq;
    memBusPkg::byteReqT byteReq;
    logic [31:0]        wordRdata;
    logic [7:0]         byteRdata;

    stepT        steps[$];
    string       stepNames[$];
    logic [7:0]  refMem [1 << `SPRAM_BYTE_AW];  // reference RAM, one byte per entry
    integer      seed = 32'h4f3a_2540;

    // read issued last cycle, checked this cycle
    logic        pendRead;
    logic        pendPort;
    string       pendName;
    logic [31:0] pendWord;
    logic [7:0]  pendByte;

    forthMemTop forthMemTop_i (
        .clk       (clk),
        .arstN     (arstN),
        .debugSel  (debugSel),
        .wordReq   (wordReq),
        .byteReq   (byteReq),
        .wordRdata (wordRdata),
        .byteRdata (byteRdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        arstN = 1'b1;
        #1;
        arstN = 1'b0;  // clean falling edge for the async reset
        repeat (16) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Simulation ran past its cycle limit");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic failNow(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            failNow($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                              name, expected, actual));
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            failNow($sformatf("Mismatch in %s: expected 0x%02h, actual 0x%02h",
                              name, expected, actual));
        end
    endtask

    task automatic waitResetLevel(input logic level);
        int cycles;
        cycles = 0;
        while (arstN !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > ResetTimeout) begin
                failNow("reset did not reach the expected level in time");
            end
        end
    endtask

    function automatic logic [31:0] modelWord(input logic [`SPRAM_WORD_AW-1:0] addr);
        return {refMem[{addr, 2'd3}], refMem[{addr, 2'd2}],
                refMem[{addr, 2'd1}], refMem[{addr, 2'd0}]};
    endfunction

    task automatic modelWordWrite(input logic [`SPRAM_WORD_AW-1:0] addr,
                                  input logic [3:0] mask, input logic [31:0] data);
        logic [3:0][7:0] lanes;
        logic [1:0]      lane;
        lanes = data;
        for (int j = 0; j < 4; j++) begin
            lane = 2'(j);
            if (mask[lane]) begin
                refMem[{addr, lane}] = lanes[lane];  // unmasked bytes keep old value
            end
        end
    endtask

    task automatic addStep(input string name, input logic port, input logic we,
                           input logic [3:0] mask, input logic [`SPRAM_BYTE_AW-1:0] addr);
        stepT s;
        s.port = port;
        s.we   = we;
        s.mask = mask;
        s.addr = addr;
        s.data = $random(seed);
        steps.push_back(s);
        stepNames.push_back(name);
    endtask

    task automatic wordStep(input string name, input logic we, input logic [3:0] mask,
                            input logic [`SPRAM_WORD_AW-1:0] addr);
        addStep(name, PortWord, we, mask, {2'b00, addr});
    endtask

    task automatic byteStep(input string name, input logic we,
                            input logic [`SPRAM_BYTE_AW-1:0] addr);
        addStep(name, PortByte, we, 4'h0, addr);
    endtask

    task automatic buildTable();
        wordStep("fullWrLo0", 1'b1, 4'hf, AddrLo0);
        wordStep("fullWrHi0", 1'b1, 4'hf, AddrHi0);
        wordStep("fullWrLo1", 1'b1, 4'hf, AddrLo1);
        wordStep("fullWrHi1", 1'b1, 4'hf, AddrHi1);
        wordStep("fullRdLo0", 1'b0, 4'h0, AddrLo0);
        wordStep("fullRdHi0", 1'b0, 4'h0, AddrHi0);
        wordStep("fullRdLo1", 1'b0, 4'h0, AddrLo1);
        wordStep("fullRdHi1", 1'b0, 4'h0, AddrHi1);
        // partial masks merge with what is already there
        wordStep("partWrLo0", 1'b1, 4'b0101, AddrLo0);
        wordStep("partRdLo0", 1'b0, 4'h0, AddrLo0);
        wordStep("partWrHi0", 1'b1, 4'b1000, AddrHi0);
        wordStep("partRdHi0", 1'b0, 4'h0, AddrHi0);
        wordStep("partWrLo1", 1'b1, 4'b0110, AddrLo1);
        wordStep("partWrHi1", 1'b1, 4'b0001, AddrHi1);
        wordStep("partRdLo1", 1'b0, 4'h0, AddrLo1);
        wordStep("partRdHi1", 1'b0, 4'h0, AddrHi1);
        // debug writes, seen through the word port
        byteStep("byteWrLane1", 1'b1, {AddrLo1, 2'd1});
        byteStep("byteWrLane3", 1'b1, {AddrHi0, 2'd3});
        byteStep("byteWrLane0", 1'b1, {AddrLo0, 2'd0});
        byteStep("byteWrLane2", 1'b1, {AddrHi1, 2'd2});
        wordStep("laneRdLo1", 1'b0, 4'h0, AddrLo1);
        wordStep("laneRdHi0", 1'b0, 4'h0, AddrHi0);
        wordStep("laneRdLo0", 1'b0, 4'h0, AddrLo0);
        wordStep("laneRdHi1", 1'b0, 4'h0, AddrHi1);
        // debug reads, pairs alternate every cycle
        byteStep("byteRdLo0L0", 1'b0, {AddrLo0, 2'd0});
        byteStep("byteRdHi0L1", 1'b0, {AddrHi0, 2'd1});
        byteStep("byteRdLo1L2", 1'b0, {AddrLo1, 2'd2});
        byteStep("byteRdHi1L3", 1'b0, {AddrHi1, 2'd3});
        byteStep("byteRdLo0L3", 1'b0, {AddrLo0, 2'd3});
        byteStep("byteRdHi0L2", 1'b0, {AddrHi0, 2'd2});
        byteStep("byteRdLo1L1", 1'b0, {AddrLo1, 2'd1});
        byteStep("byteRdHi1L0", 1'b0, {AddrHi1, 2'd0});
        // read right after write
        wordStep("b2bWordWr", 1'b1, 4'hf, AddrHi1);
        wordStep("b2bWordRd", 1'b0, 4'h0, AddrHi1);
        byteStep("b2bByteWr", 1'b1, {AddrLo0, 2'd3});
        byteStep("b2bByteRd", 1'b0, {AddrLo0, 2'd3});
        wordStep("b2bMixWr", 1'b1, 4'b1100, AddrLo1);
        byteStep("b2bMixRd", 1'b0, {AddrLo1, 2'd2});
        byteStep("b2bLaneWr", 1'b1, {AddrHi0, 2'd0});
        wordStep("b2bLaneRd", 1'b0, 4'h0, AddrHi0);
    endtask

    // write with an empty mask, so nothing changes and the outputs hold
    task automatic driveIdle();
        debugSel      = 1'b0;
        wordReq.we    = 1'b1;
        wordReq.bmsk  = 4'h0;
        wordReq.addr  = '0;
        wordReq.wdata = '0;
        byteReq.we    = 1'b1;
        byteReq.addr  = '0;
        byteReq.wdata = '0;
    endtask

    task automatic driveStep(input stepT s);
        debugSel = s.port;
        if (s.port == PortByte) begin
            byteReq.we    = s.we;
            byteReq.addr  = s.addr;
            byteReq.wdata = s.data[7:0];
        end else begin
            wordReq.we    = s.we;
            wordReq.bmsk  = s.mask;
            wordReq.addr  = s.addr[`SPRAM_WORD_AW-1:0];
            wordReq.wdata = s.data;
        end
    endtask

    task automatic modelStep(input string name, input stepT s);
        logic [`SPRAM_WORD_AW-1:0] wordAddr;
        wordAddr = s.addr[`SPRAM_WORD_AW-1:0];
        if (s.port == PortByte) begin
            if (s.we) begin
                refMem[s.addr] = s.data[7:0];
            end else begin
                pendByte = refMem[s.addr];
            end
        end else begin
            if (s.we) begin
                modelWordWrite(wordAddr, s.mask, s.data);
            end else begin
                pendWord = modelWord(wordAddr);
            end
        end
        pendRead = !s.we;
        pendPort = s.port;
        pendName = name;
    endtask

    initial begin
        driveIdle();
        pendRead = 1'b0;
        pendPort = PortWord;
        pendWord = '0;
        pendByte = '0;
        buildTable();

        waitResetLevel(1'b0);
        waitResetLevel(1'b1);
        @(negedge clk);
        checkWord("resetState", 32'h0, wordRdata);  // no read yet
        checkByte("resetState", 8'h0, byteRdata);

        for (int i = 0; i <= steps.size(); i++) begin
            @(negedge clk);
            if (i < steps.size()) begin
                driveStep(steps[i]);
            end else begin
                driveIdle();
            end
            #1;  // last read must hold while the next request is on the inputs
            if (pendRead) begin
                if (pendPort == PortByte) begin
                    checkByte(pendName, pendByte, byteRdata);
                end else begin
                    checkWord(pendName, pendWord, wordRdata);
                end
            end
            pendRead = 1'b0;
            if (i < steps.size()) begin
                modelStep(stepNames[i], steps[i]);
            end
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/forthMem_chk.sv
// Assertions on the memory subsystem top level, attached with bind.
// Covers read tag timing, byte lane steering and the output values in reset.

`timescale 1ns/1ps
`default_nettype none

module forthMemChk (
    input wire                      clk,
    input wire                      arstN,
    input wire                      debugSel,
    input wire memBusPkg::wordReqT  memReq,
    input wire bankPkg::readTagT    readTag,
    input wire [31:0]               wordRdata,
    input wire [7:0]                byteRdata
);

    logic [3:0][7:0] wordLanes;  // lane 3 is bits 31..24

    assign wordLanes = wordRdata;

    // a write leaves the tag of the last read in place
    tagHoldOnWrite: assert property (@(posedge clk) disable iff (!arstN)
        memReq.we |=> $stable(readTag))
        else $error("readTag changed after a write cycle");

    // tag captured one cycle after the read request
    tagFollowsRead: assert property (@(posedge clk) disable iff (!arstN)
        !memReq.we |=> (readTag.fromByte == $past(debugSel)))
        else $error("readTag.fromByte does not match the port of the last read");

    laneSteer: assert property (@(posedge clk)
        byteRdata == wordLanes[readTag.lane])
        else $error("byteRdata is not the tagged lane of wordRdata");

    // nothing comes out while reset is held
    zeroInReset: assert property (@(posedge clk)
        !arstN |-> (wordRdata == 32'h0 && byteRdata == 8'h0))
        else $error("read data is not zero during reset");

endmodule

bind forthMemTop forthMemChk forthMemChk_i (
    .clk       (clk),
    .arstN     (arstN),
    .debugSel  (debugSel),
    .memReq    (memReq),
    .readTag   (readTag),
    .wordRdata (wordRdata),
    .byteRdata (byteRdata)
);

`default_nettype wire

//--- rtl/forthMemTop.sv
// Top level of the stack processor memory subsystem.
// Word port for the CPU, byte port for debug, debugSel picks the owner.
// Read data on either port is valid one clock after the request.

`timescale 1ns/1ps
`default_nettype none

module forthMemTop (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     debugSel,
    input  wire memBusPkg::wordReqT  wordReq,
    input  wire memBusPkg::byteReqT  byteReq,
    output logic [31:0]             wordRdata,
    output logic [7:0]              byteRdata
);

    memBusPkg::wordReqT memReq;    // merged request
    bankPkg::readTagT   readTag;   // lane of the last read
    logic [31:0]        rawRdata;  // array output

    reqMerge reqMerge_i (
        .clk      (clk),
        .arstN    (arstN),
        .debugSel (debugSel),
        .wordReq  (wordReq),
        .byteReq  (byteReq),
        .memReq   (memReq),
        .readTag  (readTag)
    );

    spramArray spramArray_i (
        .clk      (clk),
        .arstN    (arstN),
        .memReq   (memReq),
        .rawRdata (rawRdata)
    );

    readSteer readSteer_i (
        .rawRdata  (rawRdata),
        .readTag   (readTag),
        .wordRdata (wordRdata),
        .byteRdata (byteRdata)
    );

endmodule

`default_nettype wire

//--- rtl/readSteer.sv
// Output side of the memory subsystem.
// Passes the word through and picks the byte lane recorded with the read.

`timescale 1ns/1ps
`default_nettype none

module readSteer (
    input  wire [31:0]            rawRdata,
    input  wire bankPkg::readTagT readTag,
    output logic [31:0]           wordRdata,
    output logic [7:0]            byteRdata
);

    assign wordRdata = rawRdata;

    always_comb begin
        case (readTag.lane)
            2'd0:    byteRdata = rawRdata[7:0];
            2'd1:    byteRdata = rawRdata[15:8];
            2'd2:    byteRdata = rawRdata[23:16];
            default: byteRdata = rawRdata[31:24];  // lane 3
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/reqMerge.sv
// Input side of the memory subsystem.
// debugSel hands the RAM to the byte port, which is widened here into a
// one-lane word request. The read tag is kept for the cycle the data returns.

`timescale 1ns/1ps
`default_nettype none

`include "spram_settings.svh"

module reqMerge (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     debugSel,
    input  wire memBusPkg::wordReqT  wordReq,
    input  wire memBusPkg::byteReqT  byteReq,
    output memBusPkg::wordReqT      memReq,
    output bankPkg::readTagT        readTag
);

    // request select and byte to word conversion
    always_comb begin
        memReq = wordReq;
        if (debugSel) begin
            memReq.we    = byteReq.we;
            memReq.addr  = byteReq.addr[`SPRAM_BYTE_AW-1:2];
            memReq.bmsk  = 4'b0001 << byteReq.addr[1:0];  // single lane
            memReq.wdata = {4{byteReq.wdata}};            // byte on every lane
        end
    end

    // tag of the read in flight
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readTag <= '0;
        end else if (!memReq.we) begin
            readTag.fromByte <= debugSel;
            readTag.lane     <= debugSel ? byteReq.addr[1:0] : 2'd0;  // word reads use lane 0
        end
    end

endmodule

`default_nettype wire

//--- rtl/spramArray.sv
// Bank array of the memory subsystem, 32K x 32 built from four 16K x 16 banks.
// Address bit 14 picks the lower or upper bank pair; each pair holds a high
// and a low halfword bank. Read data comes back one cycle after the request.

`timescale 1ns/1ps
`default_nettype none

`include "spram_settings.svh"

module spramArray (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire memBusPkg::wordReqT memReq,
    output logic [31:0]            rawRdata
);

    logic             halfSel;   // pair addressed this cycle
    logic             halfSelQ;  // pair of the last read
    logic [3:0]       nibHi;
    logic [3:0]       nibLo;
    bankPkg::bankReqT bankReq   [2][2];  // [pair][halfword], halfword 1 is bits 31..16
    logic [15:0]      bankRdata [2][2];

    assign halfSel = memReq.addr[`SPRAM_WORD_AW-1];

    // each byte enable covers two nibbles
    assign nibHi = {{2{memReq.bmsk[3]}}, {2{memReq.bmsk[2]}}};
    assign nibLo = {{2{memReq.bmsk[1]}}, {2{memReq.bmsk[0]}}};

    for (genvar h = 0; h < 2; h++) begin : genPair
        for (genvar w = 0; w < 2; w++) begin : genHalf
            assign bankReq[h][w] = '{
                we:      memReq.we,
                nibMask: (w == 1) ? nibHi : nibLo,
                cs:      (halfSel == 1'(h)),
                addr:    memReq.addr[`SPRAM_BANK_AW-1:0],
                wdata:   (w == 1) ? memReq.wdata[31:16] : memReq.wdata[15:0]
            };

            spramBank bank_i (
                .clk   (clk),
                .arstN (arstN),
                .req   (bankReq[h][w]),
                .rdata (bankRdata[h][w])
            );
        end
    end

    // follows the pair of the read, so it lines up with the bank registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halfSelQ <= 1'b0;
        end else if (!memReq.we) begin
            halfSelQ <= halfSel;  // writes leave the output alone
        end
    end

    assign rawRdata = {bankRdata[halfSelQ][1], bankRdata[halfSelQ][0]};

endmodule

`default_nettype wire

//--- rtl/spramBank.sv
// Behavioral 16K x 16 single-port RAM bank.
// Nibble write enables and a registered read port with one cycle of latency.
// The output holds through write cycles and unselected cycles.

`timescale 1ns/1ps
`default_nettype none

`include "spram_settings.svh"

module spramBank (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire bankPkg::bankReqT req,
    output logic [15:0]           rdata
);

    logic [15:0] mem [`SPRAM_BANK_DEPTH];  // contents survive reset

    // write port, one enable per nibble
    always_ff @(posedge clk) begin
        if (req.cs && req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.nibMask[i]) begin
                    mem[req.addr][4*i +: 4] <= req.wdata[4*i +: 4];
                end
            end
        end
    end

    // read register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdata <= '0;
        end else if (req.cs && !req.we) begin
            rdata <= mem[req.addr];  // old value kept otherwise
        end
    end

endmodule

`default_nettype wire

//--- rtl/bankPkg.sv
// Bank-level types of the memory subsystem.
// bankReqT drives one 16K x 16 bank, readTagT remembers what the last read was.

`default_nettype none

`include "spram_settings.svh"

package bankPkg;

    // request into a single bank
    typedef struct packed {
        logic                      we;
        logic [3:0]                nibMask;  // bit n writes bits 4n+3..4n
        logic                      cs;       // bank selected
        logic [`SPRAM_BANK_AW-1:0] addr;
        logic [15:0]               wdata;
    } bankReqT;

    // captured on read cycles, consumed one cycle later
    typedef struct packed {
        logic [1:0] lane;      // byte lane of the read, 3 is bits 31..24
        logic       fromByte;  // read came from the debug port
    } readTagT;

endpackage

`default_nettype wire

//--- rtl/memBusPkg.sv
// Port-level request types of the memory subsystem.
// The word port carries CPU traffic and the byte port carries debug traffic.
// Both are level requests where we high writes and we low reads.

`default_nettype none

`include "spram_settings.svh"

package memBusPkg;

    // CPU side request, 32-bit data with byte lane mask
    typedef struct packed {
        logic                      we;     // write in this cycle
        logic [3:0]                bmsk;   // bit n writes bits 8n+7..8n
        logic [`SPRAM_WORD_AW-1:0] addr;   // word address
        logic [31:0]               wdata;
    } wordReqT;

    // debug side request, one byte at a time
    // the two low address bits name the byte lane
    typedef struct packed {
        logic                      we;
        logic [`SPRAM_BYTE_AW-1:0] addr;   // byte address
        logic [7:0]                wdata;
    } byteReqT;

endpackage

`default_nettype wire

//--- include/spram_settings.svh
// Sizing of the stack processor memory subsystem.
// Included by the packages and by any RTL that slices addresses.
// Four banks of 16K x 16 give 128 KiB in total.

`ifndef SPRAM_SETTINGS_SVH
`define SPRAM_SETTINGS_SVH

// one bank
`define SPRAM_BANK_AW    14     // word address inside a bank
`define SPRAM_BANK_DEPTH 16384  // 16-bit words per bank

// port side
`define SPRAM_WORD_AW    15     // 32-bit word address, top bit picks the bank pair
`define SPRAM_BYTE_AW    17     // byte address of the debug port

`endif
